//--- common/tsa_macros.svh
`ifndef TSA_MACROS_SVH
`define TSA_MACROS_SVH

// ordered-set symbol codes
`define TSA_COM           8'hBC  // comma, always symbol 0
`define TSA_PAD           8'hF7  // link/lane not assigned yet
`define TSA_TS1_ID        8'h4A
`define TSA_TS2_ID        8'h45
`define TSA_NFTS          8'hFF  // symbol 3
`define TSA_RATE_SUPPORT  8'h02  // symbol 4

// link number this port hands out when it is the downstream side
`define TSA_LINK_NUM      8'h01

// training state codes, upper nibble of ts_info
`define TSA_ST_POLL       4'd2
`define TSA_ST_CFG        4'd3

// substate codes, lower nibble of ts_info
`define TSA_SUB_POLL_ACTIVE 4'd1
`define TSA_SUB_POLL_CFG    4'd2
`define TSA_SUB_LW_START    4'd0
`define TSA_SUB_LW_ACC      4'd1

// number of ordered sets to receive before a transition
`define TSA_RX_NUM_LONG   8'd8   // polling phases and linkwidth.start
`define TSA_RX_NUM_SHORT  8'd2   // usp linkwidth.accept
`define TSA_RX_NUM_NONE   8'd0   // dsp linkwidth.accept moves on at once

// mode input, 0 means upstream port
`define TSA_MODE_DSP      1'b1

// mask bit per symbol, symbol 0 sits in the top bit like in ts_word_t
`define TSA_MASK_ALL      16'hFFFF
`define TSA_MASK_SYM1     14
`define TSA_MASK_SYM2     13

`endif

//--- common/tsa_pkg.sv
`default_nettype none

package tsa_pkg;

    // one 8b symbol of an ordered set
    typedef logic [7:0] symbol_t;

    // full 16-symbol ordered set, symbol 0 in bits 127:120
    typedef logic [127:0] ts_word_t;

    // one bit per symbol, 1 = compared
    typedef logic [15:0] ts_mask_t;

    typedef logic [7:0] rx_count_t;

    // [7:4] training state, [3:0] substate
    typedef logic [7:0] ts_info_t;

    typedef logic [3:0] lane_id_t;

    // which expectation set is loaded
    typedef enum logic [2:0] {
        PHASE_NONE        = 3'd0,
        PHASE_POLL_ACTIVE = 3'd1,
        PHASE_POLL_CFG    = 3'd2,
        PHASE_CFG_LW_START = 3'd3,
        PHASE_CFG_LW_ACC  = 3'd4
    } tsa_phase_e;

    // receive side is either waiting for an update or counting
    typedef enum logic {
        RX_IDLE  = 1'b0,
        RX_ARMED = 1'b1
    } rx_state_e;

endpackage

`default_nettype wire

//--- tsa/ts_expect_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsa_macros.svh"

module ts_expect_decode (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire tsa_pkg::ts_info_t  ts_info,
    input  wire logic               ts_update,
    input  wire logic               mode,
    input  wire tsa_pkg::symbol_t   link_num,
    output logic                    ts_update_ack,
    output logic                    accept,
    output logic                    armed,
    output logic                    is_dsp,
    output tsa_pkg::tsa_phase_e     phase,
    output tsa_pkg::ts_word_t       expected,
    output tsa_pkg::ts_mask_t       mask,
    output tsa_pkg::rx_count_t      target
);

    import tsa_pkg::*;

    rx_state_e  state;
    logic       take;        // update accepted at this edge
    logic       dsp_nxt;
    tsa_phase_e phase_nxt;
    rx_count_t  target_nxt;
    ts_word_t   exp_nxt;
    ts_mask_t   mask_nxt;
    symbol_t    id_sym;

    // level request, single ack cycle, so a held request is not taken twice
    assign take    = ts_update && !ts_update_ack;
    assign dsp_nxt = (mode == `TSA_MODE_DSP);

    always_comb begin
        phase_nxt = PHASE_NONE;
        if (ts_info[7:4] == `TSA_ST_POLL) begin
            if (ts_info[3:0] == `TSA_SUB_POLL_ACTIVE)
                phase_nxt = PHASE_POLL_ACTIVE;
            else if (ts_info[3:0] == `TSA_SUB_POLL_CFG)
                phase_nxt = PHASE_POLL_CFG;
        end else if (ts_info[7:4] == `TSA_ST_CFG) begin
            if (ts_info[3:0] == `TSA_SUB_LW_START)
                phase_nxt = PHASE_CFG_LW_START;
            else if (ts_info[3:0] == `TSA_SUB_LW_ACC)
                phase_nxt = PHASE_CFG_LW_ACC;
        end
    end

    // expected ordered set, mask and count for the decoded phase
    always_comb begin
        id_sym     = (phase_nxt == PHASE_POLL_CFG) ? `TSA_TS2_ID : `TSA_TS1_ID;
        exp_nxt    = {16{id_sym}};            // symbols 6..15
        exp_nxt[127:120] = `TSA_COM;
        exp_nxt[119:112] = `TSA_PAD;
        exp_nxt[111:104] = `TSA_PAD;
        exp_nxt[103:96]  = `TSA_NFTS;
        exp_nxt[95:88]   = `TSA_RATE_SUPPORT;
        exp_nxt[87:80]   = 8'h00;
        mask_nxt   = `TSA_MASK_ALL;
        target_nxt = `TSA_RX_NUM_LONG;
        case (phase_nxt)
            PHASE_CFG_LW_START: begin
                mask_nxt[`TSA_MASK_SYM1] = 1'b0;   // link number checked later
            end
            PHASE_CFG_LW_ACC: begin
                exp_nxt[119:112] = link_num;       // partner echoes our link
                mask_nxt[`TSA_MASK_SYM2] = 1'b0;   // lane number checked later
                target_nxt = dsp_nxt ? `TSA_RX_NUM_NONE : `TSA_RX_NUM_SHORT;
            end
            PHASE_NONE: target_nxt = `TSA_RX_NUM_NONE;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= RX_IDLE;
            ts_update_ack <= 1'b0;
            phase         <= PHASE_NONE;
            is_dsp        <= 1'b0;
            target        <= '0;
        end else begin
            ts_update_ack <= take;
            if (take) begin
                // an unknown code parks the receiver, nothing is counted
                state  <= (phase_nxt == PHASE_NONE) ? RX_IDLE : RX_ARMED;
                phase  <= phase_nxt;
                is_dsp <= dsp_nxt;
                target <= target_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            expected <= exp_nxt;
            mask     <= mask_nxt;
        end
    end

    assign accept = ts_update_ack;  // same cycle as the ack by definition
    assign armed  = (state == RX_ARMED);

    // the requester drops ts_update while the ack is high, so no second accept follows
    update_dropped_on_ack: assert property (
        @(posedge clk) disable iff (rst) ts_update_ack |-> !ts_update
    );

endmodule

`default_nettype wire

//--- tsa/ts_match_count.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsa_macros.svh"

module ts_match_count (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                remote_ts_valid,
    input  wire tsa_pkg::ts_word_t   remote_ts,
    input  wire tsa_pkg::ts_word_t   expected,
    input  wire tsa_pkg::ts_mask_t   mask,
    input  wire tsa_pkg::rx_count_t  target,
    input  wire tsa_pkg::tsa_phase_e phase,
    input  wire logic                is_dsp,
    input  wire logic                armed,
    input  wire logic                accept,
    input  wire logic                ts_sent_enough,
    input  wire tsa_pkg::lane_id_t   lane_num,
    output logic                     match_vld,
    output logic                     count_vld,
    output tsa_pkg::symbol_t         rx_symbol1,
    output tsa_pkg::symbol_t         rx_symbol2,
    output logic                     target_hit
);

    import tsa_pkg::*;

    ts_mask_t  sym_ok;
    logic      masked_match;
    logic      phase_ok;
    logic      sent_ok;
    logic      reached;
    logic      hit_cond;
    logic      hit_done;   // one transition per update
    rx_count_t count;
    symbol_t   lane_sym;

    assign lane_sym = {4'h0, lane_num};

    // mask bit 15-i covers symbol i
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            sym_ok[15-i] = !mask[15-i] ||
                           (remote_ts[127-8*i -: 8] == expected[127-8*i -: 8]);
        end
    end

    assign masked_match = &sym_ok;

    always_comb begin
        phase_ok = 1'b1;
        if (phase == PHASE_CFG_LW_START && is_dsp)
            phase_ok = (remote_ts[119:112] == `TSA_LINK_NUM);
        else if (phase == PHASE_CFG_LW_ACC && !is_dsp)
            phase_ok = (remote_ts[111:104] == lane_sym);
    end

    // polling may only move on once our own side has sent enough
    assign sent_ok  = (phase == PHASE_POLL_ACTIVE || phase == PHASE_POLL_CFG) ?
                      ts_sent_enough : 1'b1;
    // a zero target is met in the accept cycle, the old count is stale there
    assign reached  = accept ? (target == '0) : (!hit_done && count >= target);
    assign hit_cond = armed && !target_hit && sent_ok && reached;

    always_ff @(posedge clk) begin
        if (rst) begin
            match_vld <= 1'b0;
            count_vld <= 1'b0;
        end else begin
            match_vld <= remote_ts_valid && armed && masked_match;
            count_vld <= remote_ts_valid && armed && masked_match && phase_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (remote_ts_valid) begin
            rx_symbol1 <= remote_ts[119:112];
            rx_symbol2 <= remote_ts[111:104];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count      <= '0;
            target_hit <= 1'b0;
            hit_done   <= 1'b0;
        end else begin
            target_hit <= hit_cond;
            if (accept) begin
                count    <= '0;
                hit_done <= 1'b0;
            end else if (target_hit) begin
                count    <= '0;
                hit_done <= 1'b1;
            end else if (count_vld && count != 8'hFF) begin
                count <= count + 8'd1;     // saturates while sent_enough is low
            end
        end
    end

    // a hit may only coincide with a new update that disarms the receiver
    hit_while_armed: assert property (
        @(posedge clk) disable iff (rst) target_hit |-> (armed || accept)
    );

endmodule

`default_nettype wire

//--- tsa/ts_transition_result.sv
`timescale 1ns/1ps
`default_nettype none

module ts_transition_result (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                accept,
    input  wire logic                target_hit,
    input  wire logic                match_vld,
    input  wire logic                count_vld,
    input  wire logic                is_dsp,
    input  wire tsa_pkg::tsa_phase_e phase,
    input  wire tsa_pkg::symbol_t    rx_symbol1,
    input  wire tsa_pkg::symbol_t    rx_symbol2,
    output logic                     tsa_p_a2c,
    output logic                     tsa_p2c,
    output logic                     tsa_c_ws2wa,
    output logic                     tsa_c_wa2nw,
    output tsa_pkg::symbol_t         rcv_link_num,
    output tsa_pkg::symbol_t         rcv_lane_num,
    output logic                     rcv_link_num_vld,
    output logic                     rcv_lane_num_vld
);

    import tsa_pkg::*;

    logic usp_lw_start;
    logic usp_lw_acc;

    // a match pulse from before the update belongs to the old phase
    assign usp_lw_start = match_vld && !accept && !is_dsp &&
                          (phase == PHASE_CFG_LW_START);
    assign usp_lw_acc   = match_vld && !accept && !is_dsp &&
                          (phase == PHASE_CFG_LW_ACC);

    always_ff @(posedge clk) begin
        if (rst || accept) begin
            tsa_p_a2c   <= 1'b0;
            tsa_p2c     <= 1'b0;
            tsa_c_ws2wa <= 1'b0;
            tsa_c_wa2nw <= 1'b0;
        end else if (target_hit) begin
            case (phase)
                PHASE_POLL_ACTIVE:  tsa_p_a2c   <= 1'b1;
                PHASE_POLL_CFG:     tsa_p2c     <= 1'b1;
                PHASE_CFG_LW_START: tsa_c_ws2wa <= 1'b1;
                PHASE_CFG_LW_ACC:   tsa_c_wa2nw <= 1'b1;
                default: ;
            endcase
        end
    end

    // link number stays valid into linkwidth.accept, where it is echoed
    always_ff @(posedge clk) begin
        if (rst) begin
            rcv_link_num     <= '0;
            rcv_link_num_vld <= 1'b0;
        end else if (usp_lw_start) begin
            rcv_link_num     <= rx_symbol1;
            rcv_link_num_vld <= 1'b1;
        end
    end

    // lane is shown even when wrong, valid only if it was ours
    always_ff @(posedge clk) begin
        if (rst) begin
            rcv_lane_num     <= '0;
            rcv_lane_num_vld <= 1'b0;
        end else if (usp_lw_acc) begin
            rcv_lane_num     <= rx_symbol2;
            rcv_lane_num_vld <= count_vld;
        end
    end

    // phase only changes on accept, which clears every flag
    one_flag_at_most: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({tsa_p_a2c, tsa_p2c, tsa_c_ws2wa, tsa_c_wa2nw})
    );

endmodule

`default_nettype wire

//--- tsa/tsa_top.sv
`timescale 1ns/1ps
`default_nettype none

module tsa_top (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire tsa_pkg::ts_info_t  ts_info,
    input  wire logic               ts_update,
    input  wire logic               mode,
    input  wire logic               ts_sent_enough,
    input  wire tsa_pkg::lane_id_t  lane_num,
    input  wire logic               remote_ts_valid,
    input  wire tsa_pkg::ts_word_t  remote_ts,
    output logic                    ts_update_ack,
    output tsa_pkg::symbol_t        rcv_link_num,
    output tsa_pkg::symbol_t        rcv_lane_num,
    output logic                    rcv_link_num_vld,
    output logic                    rcv_lane_num_vld,
    output logic                    tsa_p_a2c,
    output logic                    tsa_p2c,
    output logic                    tsa_c_ws2wa,
    output logic                    tsa_c_wa2nw
);

    import tsa_pkg::*;

    logic       accept;
    logic       armed;
    logic       is_dsp;
    tsa_phase_e phase;
    ts_word_t   expected;
    ts_mask_t   mask;
    rx_count_t  target;
    logic       match_vld;
    logic       count_vld;
    logic       target_hit;
    symbol_t    rx_symbol1;
    symbol_t    rx_symbol2;

    ts_expect_decode u_decode (
        .clk           (clk),
        .rst           (rst),
        .ts_info       (ts_info),
        .ts_update     (ts_update),
        .mode          (mode),
        .link_num      (rcv_link_num),  // captured in usp linkwidth.start
        .ts_update_ack (ts_update_ack),
        .accept        (accept),
        .armed         (armed),
        .is_dsp        (is_dsp),
        .phase         (phase),
        .expected      (expected),
        .mask          (mask),
        .target        (target)
    );

    ts_match_count u_match (
        .clk             (clk),
        .rst             (rst),
        .remote_ts_valid (remote_ts_valid),
        .remote_ts       (remote_ts),
        .expected        (expected),
        .mask            (mask),
        .target          (target),
        .phase           (phase),
        .is_dsp          (is_dsp),
        .armed           (armed),
        .accept          (accept),
        .ts_sent_enough  (ts_sent_enough),
        .lane_num        (lane_num),
        .match_vld       (match_vld),
        .count_vld       (count_vld),
        .rx_symbol1      (rx_symbol1),
        .rx_symbol2      (rx_symbol2),
        .target_hit      (target_hit)
    );

    ts_transition_result u_result (
        .clk              (clk),
        .rst              (rst),
        .accept           (accept),
        .target_hit       (target_hit),
        .match_vld        (match_vld),
        .count_vld        (count_vld),
        .is_dsp           (is_dsp),
        .phase            (phase),
        .rx_symbol1       (rx_symbol1),
        .rx_symbol2       (rx_symbol2),
        .tsa_p_a2c        (tsa_p_a2c),
        .tsa_p2c          (tsa_p2c),
        .tsa_c_ws2wa      (tsa_c_ws2wa),
        .tsa_c_wa2nw      (tsa_c_wa2nw),
        .rcv_link_num     (rcv_link_num),
        .rcv_lane_num     (rcv_lane_num),
        .rcv_link_num_vld (rcv_link_num_vld),
        .rcv_lane_num_vld (rcv_lane_num_vld)
    );

endmodule

`default_nettype wire

//--- sim/tsa_tb_table.svh
`ifndef TSA_TB_TABLE_SVH
`define TSA_TB_TABLE_SVH

// columns: info, mode, lane, sent_enough, good sets, corrupted sets, link/lane symbol,
//          expected flags {p_a2c, p2c, ws2wa, wa2nw}, link, link vld, lane, lane vld

localparam ts_info_t POLL_ACT = {`TSA_ST_POLL, `TSA_SUB_POLL_ACTIVE};
localparam ts_info_t POLL_CFG = {`TSA_ST_POLL, `TSA_SUB_POLL_CFG};
localparam ts_info_t LW_START = {`TSA_ST_CFG, `TSA_SUB_LW_START};
localparam ts_info_t LW_ACC   = {`TSA_ST_CFG, `TSA_SUB_LW_ACC};
localparam ts_info_t NO_STATE = 8'h50;   // decodes to no phase

localparam logic DSP = `TSA_MODE_DSP;
localparam logic USP = ~`TSA_MODE_DSP;

localparam int NUM_ROWS = 11;

row_t rows [NUM_ROWS] = '{
    '{POLL_ACT, DSP, 4'd3, 1'b1, 8, 3, 8'h00,         4'b1000, 8'h00, 1'b0, 8'h00, 1'b0},
    '{POLL_ACT, DSP, 4'd3, 1'b1, 7, 3, 8'h00,         4'b0000, 8'h00, 1'b0, 8'h00, 1'b0},
    '{POLL_ACT, DSP, 4'd3, 1'b0, 8, 0, 8'h00,         4'b0000, 8'h00, 1'b0, 8'h00, 1'b0},
    '{POLL_CFG, DSP, 4'd3, 1'b1, 8, 2, 8'h00,         4'b0100, 8'h00, 1'b0, 8'h00, 1'b0},
    '{LW_START, DSP, 4'd3, 1'b1, 8, 1, `TSA_PAD,      4'b0000, 8'h00, 1'b0, 8'h00, 1'b0},
    '{LW_START, DSP, 4'd3, 1'b1, 8, 2, `TSA_LINK_NUM, 4'b0010, 8'h00, 1'b0, 8'h00, 1'b0},
    '{LW_ACC,   DSP, 4'd3, 1'b1, 0, 0, 8'h00,         4'b0001, 8'h00, 1'b0, 8'h00, 1'b0},
    '{LW_START, USP, 4'd3, 1'b1, 8, 2, 8'h05,         4'b0010, 8'h05, 1'b1, 8'h00, 1'b0},
    '{LW_ACC,   USP, 4'd3, 1'b1, 1, 1, 8'h06,         4'b0000, 8'h05, 1'b1, 8'h06, 1'b0},
    '{LW_ACC,   USP, 4'd3, 1'b1, 2, 1, 8'h03,         4'b0001, 8'h05, 1'b1, 8'h03, 1'b1},
    '{NO_STATE, USP, 4'd3, 1'b1, 8, 0, 8'h00,         4'b0000, 8'h05, 1'b1, 8'h03, 1'b1}
};

`endif

//--- sim/tb_tsa.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsa_macros.svh"

module tb_tsa;

    import tsa_pkg::*;

    typedef struct packed {
        ts_info_t   info;
        logic       mode;
        lane_id_t   lane;
        logic       sent;
        int         n_good;
        int         n_bad;
        symbol_t    sym;         // link symbol in linkwidth.start, lane in accept
        logic [3:0] exp_flags;
        symbol_t    exp_link;
        logic       exp_link_vld;
        symbol_t    exp_lane;
        logic       exp_lane_vld;
    } row_t;

`include "tsa_tb_table.svh"

    logic       clk;
    logic       rst;
    ts_info_t   ts_info;
    logic       ts_update;
    logic       mode;
    logic       ts_sent_enough;
    lane_id_t   lane_num;
    logic       remote_ts_valid;
    ts_word_t   remote_ts;
    logic       ts_update_ack;
    symbol_t    rcv_link_num;
    symbol_t    rcv_lane_num;
    logic       rcv_link_num_vld;
    logic       rcv_lane_num_vld;
    logic       tsa_p_a2c;
    logic       tsa_p2c;
    logic       tsa_c_ws2wa;
    logic       tsa_c_wa2nw;
    logic [3:0] flags;
    logic [15:0] lfsr_state = 16'd5;
    symbol_t    link_seen = 8'h00;   // link number the usp side should hold by now

    assign flags = {tsa_p_a2c, tsa_p2c, tsa_c_ws2wa, tsa_c_wa2nw};

    tsa_top dut (
        .clk              (clk),
        .rst              (rst),
        .ts_info          (ts_info),
        .ts_update        (ts_update),
        .mode             (mode),
        .ts_sent_enough   (ts_sent_enough),
        .lane_num         (lane_num),
        .remote_ts_valid  (remote_ts_valid),
        .remote_ts        (remote_ts),
        .ts_update_ack    (ts_update_ack),
        .rcv_link_num     (rcv_link_num),
        .rcv_lane_num     (rcv_lane_num),
        .rcv_link_num_vld (rcv_link_num_vld),
        .rcv_lane_num_vld (rcv_lane_num_vld),
        .tsa_p_a2c        (tsa_p_a2c),
        .tsa_p2c          (tsa_p2c),
        .tsa_c_ws2wa      (tsa_c_ws2wa),
        .tsa_c_wa2nw      (tsa_c_wa2nw)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [3:0] val);
        val = 4'h0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[2:0], lfsr_state[0]};
        end
    endtask

    // ordered set the partner sends when everything is right
    function automatic ts_word_t good_ts(input ts_info_t info, input symbol_t sym,
                                         input symbol_t link);
        ts_word_t w;
        w = {16{(info == POLL_CFG) ? `TSA_TS2_ID : `TSA_TS1_ID}};
        w[127:120] = `TSA_COM;
        w[119:112] = `TSA_PAD;
        w[111:104] = `TSA_PAD;
        w[103:96]  = `TSA_NFTS;
        w[95:88]   = `TSA_RATE_SUPPORT;
        w[87:80]   = 8'h00;
        if (info == LW_START) begin
            w[119:112] = sym;
        end else if (info == LW_ACC) begin
            w[119:112] = link;   // echo of the captured link
            w[111:104] = sym;
        end
        return w;
    endfunction

    function automatic int ignored_sym(input ts_info_t info);
        if (info == LW_START)
            return 1;
        if (info == LW_ACC)
            return 2;
        return -1;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flags(input logic [3:0] got, input logic [3:0] exp,
                               input string what);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                    $time, what, got, exp));
    endtask

    task automatic check_symbol(input symbol_t got, input symbol_t exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                    $time, what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                    $time, what, got, exp));
    endtask

    task automatic do_update(input row_t r);
        int waited;
        logic got_ack;
        waited = 0;
        got_ack = 1'b0;
        ts_info = r.info;
        mode = r.mode;
        lane_num = r.lane;
        ts_sent_enough = r.sent;
        ts_update = 1'b1;
        while (!got_ack) begin
            @(posedge clk);
            #1;
            if (ts_update_ack) begin
                got_ack = 1'b1;
            end else begin
                waited++;
                if (waited >= 4)
                    stop_on_error("update handshake got no ack within 4 cycles");
            end
        end
        ts_update = 1'b0;   // dropped in the ack cycle
        @(posedge clk);
        #1;
        check_bit(ts_update_ack, 1'b0, "ack one cycle after the ack");
        check_flags(flags, 4'b0000, "flags after update");
    endtask

    task automatic send_sets(input row_t r);
        int good_left;
        int bad_left;
        int idx;
        logic send_bad;
        logic last_bad;
        logic [3:0] bits;
        ts_word_t w;
        good_left = r.n_good;
        bad_left = r.n_bad;
        last_bad = 1'b0;
        while (good_left > 0 || bad_left > 0) begin
            draw_bits(2, bits);
            repeat (bits[1:0]) begin   // idle gap of 0 to 3 cycles
                @(posedge clk);
                #1;
            end
            w = good_ts(r.info, r.sym, link_seen);
            send_bad = (bad_left > 0) && (good_left == 0 || !last_bad);
            if (send_bad) begin
                draw_bits(4, bits);
                idx = int'(bits);
                if (idx == ignored_sym(r.info))
                    idx = 0;   // must hit a compared symbol
                w[127 - 8 * idx -: 8] = w[127 - 8 * idx -: 8] ^ 8'hFF;
                bad_left--;
            end else begin
                good_left--;
            end
            last_bad = send_bad;
            remote_ts = w;
            remote_ts_valid = 1'b1;
            @(posedge clk);
            #1;
            remote_ts_valid = 1'b0;
        end
    endtask

    // no flag expected means the whole window is watched
    task automatic wait_flag(input logic [3:0] exp);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (n < 6 && !seen) begin
            @(posedge clk);
            #1;
            n++;
            seen = (exp != 4'b0000) && (flags != 4'b0000);
        end
    endtask

    initial begin
        repeat (NUM_ROWS * 200) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 NUM_ROWS * 200);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        row_t r;
        ts_info = '0;
        ts_update = 1'b0;
        mode = 1'b0;
        ts_sent_enough = 1'b0;
        lane_num = '0;
        remote_ts_valid = 1'b0;
        remote_ts = '0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flags(flags, 4'b0000, "flags after reset");
        check_bit(ts_update_ack, 1'b0, "ack after reset");
        check_bit(rcv_link_num_vld, 1'b0, "link valid after reset");
        check_bit(rcv_lane_num_vld, 1'b0, "lane valid after reset");
        check_symbol(rcv_link_num, 8'h00, "link number after reset");
        check_symbol(rcv_lane_num, 8'h00, "lane number after reset");

        for (int i = 0; i < NUM_ROWS; i++) begin
            r = rows[i];
            do_update(r);
            send_sets(r);
            wait_flag(r.exp_flags);
            check_flags(flags, r.exp_flags, $sformatf("row %0d flags", i));
            check_symbol(rcv_link_num, r.exp_link, $sformatf("row %0d link number", i));
            check_bit(rcv_link_num_vld, r.exp_link_vld, $sformatf("row %0d link valid", i));
            check_symbol(rcv_lane_num, r.exp_lane, $sformatf("row %0d lane number", i));
            check_bit(rcv_lane_num_vld, r.exp_lane_vld, $sformatf("row %0d lane valid", i));
            link_seen = r.exp_link;
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
+incdir+sim
common/tsa_pkg.sv
tsa/ts_expect_decode.sv
tsa/ts_match_count.sv
tsa/ts_transition_result.sv
tsa/tsa_top.sv
sim/tb_tsa.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the analyzer testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_tsa -o tb_tsa
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_tsa
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
